// File: pi_pkg.sv
// shared widths, acknowledge codes and device sizing for the PI-bus slave, imported by the RTL
package pi_pkg;

   localparam int ADDR_W = 30;          // bus word address
   localparam int DATA_W = 32;          // bus data word
   localparam int OPC_W  = 4;           // transfer opcode

   // slave acknowledge codes, one-hot apart from idle
   typedef enum logic [2:0] {
      ACK_IDLE = 3'b000,
      ACK_RDY  = 3'b001,
      ACK_WAT  = 3'b010,
      ACK_ERR  = 3'b100
   } ack_t;

   localparam logic [OPC_W-1:0] OPC_WORD = 4'b0010;  // single word transfer, nothing else

   localparam int REG_COUNT = 16;       // device word registers
   localparam int REG_AW    = 4;        // register index bits

   localparam int WBUF_DEPTH     = 4;   // posted write entries
   localparam int RBUF_DEPTH     = 2;   // read return words
   localparam int DRAIN_INTERVAL = 4;   // cycles per write buffer drain
   localparam int RD_LAT         = 2;   // register lookup stages

   // one posted write, register index above data
   typedef struct packed {
      logic [REG_AW-1:0] idx;
      logic [DATA_W-1:0] data;
   } wr_entry_t;

endpackage

// File: pi_dev_if.sv
// request and status bundle between the PI-bus slave FSM and the register device
`timescale 1ns/1ps

interface pi_dev_if;
   import pi_pkg::*;

   logic              req_valid;   // one pulse per accepted request
   logic              req_read;    // 1 read, 0 write
   logic [ADDR_W-1:0] req_addr;    // full word address, device decodes range
   logic [OPC_W-1:0]  req_opc;
   logic [DATA_W-1:0] req_wdata;
   logic              abort;       // drop outstanding transfer
   logic              filled;      // write buffer full
   logic              data_ready;  // read word waiting in return buffer
   logic              error;       // decode of current request fields
   logic [DATA_W-1:0] rdata;       // head of return buffer

   modport fsm (
      output req_valid, req_read, req_addr, req_opc, req_wdata, abort,
      input  filled, data_ready, error, rdata
   );

   modport dev (
      input  req_valid, req_read, req_addr, req_opc, req_wdata, abort,
      output filled, data_ready, error, rdata
   );

endinterface

// File: pi_fifo.sv
// small synchronous circular buffer with a payload type parameter, for write posting and read return
`timescale 1ns/1ps

module pi_fifo #(
   parameter type T     = logic [pi_pkg::DATA_W-1:0],
   parameter int  DEPTH = 2
) (
   input  logic clk,
   input  logic rst_n,
   input  logic push,
   input  logic pop,
   input  logic flush,
   input  T     wdata,
   output T     rdata,
   output logic full,
   output logic empty
);

   T                             mem [DEPTH];
   logic [$clog2(DEPTH)-1:0]     wr_ptr;
   logic [$clog2(DEPTH)-1:0]     rd_ptr;
   logic [$clog2(DEPTH+1)-1:0]   count;
   logic                         do_push;
   logic                         do_pop;

   assign full    = (count == DEPTH);
   assign empty   = (count == 0);
   assign do_push = push && !full;       // push into a full buffer is dropped
   assign do_pop  = pop && !empty;       // pop of an empty buffer is dropped
   assign rdata   = mem[rd_ptr];         // head shows without a pop

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else if (flush)
      begin
         wr_ptr <= '0;                   // everything gone in one cycle
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_push)
            wr_ptr <= (wr_ptr == DEPTH-1) ? '0 : wr_ptr + 1'b1;  // wrap for any depth
         if (do_pop)
            rd_ptr <= (rd_ptr == DEPTH-1) ? '0 : rd_ptr + 1'b1;
         if (do_push && !do_pop)
            count <= count + 1'b1;
         else if (do_pop && !do_push)
            count <= count - 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (do_push)
         mem[wr_ptr] <= wdata;
   end

endmodule

// File: pi_reg_device.sv
// 16-word register device behind the PI-bus slave, posts writes and returns reads after a lookup
`timescale 1ns/1ps

module pi_reg_device (
   input logic   clk,
   input logic   rst_n,
   pi_dev_if.dev dev
);
   import pi_pkg::*;

   logic [DATA_W-1:0]                 regs [REG_COUNT];
   logic [REG_AW-1:0]                 req_idx;
   logic                              req_ok;
   wr_entry_t                         wb_in;
   wr_entry_t                         wb_head;
   logic                              wb_push;
   logic                              wb_pop;
   logic                              wb_full;
   logic                              wb_empty;
   logic                              wr_wait;     // write held off by a full buffer
   logic [$clog2(DRAIN_INTERVAL)-1:0] drain_cnt;
   logic                              rd_wait;     // read waiting for writes to drain
   logic                              rd_go;
   logic [RD_LAT-1:0]                 lk_vld;
   logic [DATA_W-1:0]                 lk_data [RD_LAT];
   logic                              rb_empty;

   assign req_idx   = dev.req_addr[REG_AW-1:0];
   assign dev.error = (dev.req_addr >= REG_COUNT) || (dev.req_opc != OPC_WORD);
   assign req_ok    = dev.req_valid && !dev.error;

   // the FSM keeps the request fields stable while a write waits, so they feed the buffer
   assign wb_in   = '{idx: req_idx, data: dev.req_wdata};
   assign wb_push = !wb_full && !dev.abort && ((req_ok && !dev.req_read) || wr_wait);
   assign wb_pop  = !wb_empty && (drain_cnt == DRAIN_INTERVAL-1);
   assign rd_go   = rd_wait && wb_empty && !dev.abort;  // reads see every posted write

   assign dev.filled     = wb_full;
   assign dev.data_ready = !rb_empty;

   pi_fifo #(.T(wr_entry_t), .DEPTH(WBUF_DEPTH)) wbuf_inst (
      .clk   (clk),
      .rst_n (rst_n),
      .push  (wb_push),
      .pop   (wb_pop),
      .flush (1'b0),                  // posted writes always land
      .wdata (wb_in),
      .rdata (wb_head),
      .full  (wb_full),
      .empty (wb_empty)
   );

   // FSM answers RDY on the edge where data_ready is high, so the head is consumed there
   pi_fifo #(.T(logic [DATA_W-1:0]), .DEPTH(RBUF_DEPTH)) rbuf_inst (
      .clk   (clk),
      .rst_n (rst_n),
      .push  (lk_vld[RD_LAT-1]),
      .pop   (dev.data_ready),
      .flush (dev.abort),             // stale word never reaches the next read
      .wdata (lk_data[RD_LAT-1]),
      .rdata (dev.rdata),
      .full  (),
      .empty (rb_empty)
   );

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         wr_wait   <= 1'b0;
         rd_wait   <= 1'b0;
         drain_cnt <= '0;
         lk_vld    <= '0;
      end
      else
      begin
         if (dev.abort)
            wr_wait <= 1'b0;
         else if (req_ok && !dev.req_read && wb_full)
            wr_wait <= 1'b1;              // back-pressure, FSM holds WAT
         else if (wb_push)
            wr_wait <= 1'b0;
         if (dev.abort)
            rd_wait <= 1'b0;
         else if (req_ok && dev.req_read)
            rd_wait <= 1'b1;
         else if (rd_go)
            rd_wait <= 1'b0;
         if (wb_empty || wb_pop)
            drain_cnt <= '0;              // interval restarts per entry
         else
            drain_cnt <= drain_cnt + 1'b1;
         lk_vld[0] <= rd_go;
         for (int i = 1; i < RD_LAT; i++)
            lk_vld[i] <= lk_vld[i-1];     // lookup pipeline
         if (dev.abort)
            lk_vld <= '0;                 // kill lookup in flight
      end
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < REG_COUNT; i++)
            regs[i] <= '0;
      end
      else if (wb_pop)
         regs[wb_head.idx] <= wb_head.data;   // one drain per interval
   end

   always_ff @(posedge clk)
   begin
      lk_data[0] <= regs[req_idx];
      for (int i = 1; i < RD_LAT; i++)
         lk_data[i] <= lk_data[i-1];
   end

endmodule

// File: pi_slave_fsm.sv
// PI-bus slave control FSM, accepts one transfer at a time and answers with acknowledge codes
`timescale 1ns/1ps

module pi_slave_fsm (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      sel,
   input  logic [pi_pkg::ADDR_W-1:0] addr,
   input  logic [pi_pkg::OPC_W-1:0]  opc,
   input  logic                      read,
   input  logic [pi_pkg::DATA_W-1:0] din,
   input  logic                      tout,
   output pi_pkg::ack_t              ack,
   output logic [pi_pkg::DATA_W-1:0] dout,
   pi_dev_if.fsm                     dev
);
   import pi_pkg::*;

   typedef enum logic {
      ADDRESS,                         // waiting for sel
      DATA_WAIT                        // request issued, waiting for completion
   } state_t;

   state_t state;
   logic   accept;
   logic   wr_done;
   logic   rd_done;
   logic   req_err;
   logic   abandon;

   assign accept  = (state == ADDRESS) && sel;
   assign req_err = dev.req_valid && dev.error;         // error only valid with the pulse
   assign wr_done = !dev.req_read && !dev.filled;       // slot free, entry goes in
   assign rd_done = dev.req_read && dev.data_ready;     // word at buffer head
   assign abandon = tout && (ack == ACK_WAT);           // master gave up

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state         <= ADDRESS;
         ack           <= ACK_IDLE;
         dout          <= '0;
         dev.req_valid <= 1'b0;
         dev.abort     <= 1'b0;
      end
      else
      begin
         dev.req_valid <= 1'b0;         // both are single pulses
         dev.abort     <= 1'b0;
         case (state)
            ADDRESS:
            begin
               ack  <= ACK_IDLE;
               dout <= '0;
               if (accept)
               begin
                  dev.req_valid <= 1'b1;
                  state         <= DATA_WAIT;
               end
            end
            DATA_WAIT:
            begin
               if (req_err)
               begin
                  ack   <= ACK_ERR;     // bad address or opcode
                  dout  <= '0;
                  state <= ADDRESS;
               end
               else if (wr_done)
               begin
                  ack   <= ACK_RDY;
                  dout  <= '0;          // no data on a write
                  state <= ADDRESS;
               end
               else if (rd_done)
               begin
                  ack   <= ACK_RDY;
                  dout  <= dev.rdata;   // valid only with this RDY
                  state <= ADDRESS;
               end
               else if (abandon)
               begin
                  ack       <= ACK_IDLE;
                  dout      <= '0;
                  dev.abort <= 1'b1;    // device drops the read
                  state     <= ADDRESS;
               end
               else
               begin
                  ack  <= ACK_WAT;      // back-pressure, held as long as needed
                  dout <= '0;
               end
            end
            default:
            begin
               ack   <= ACK_IDLE;
               dout  <= '0;
               state <= ADDRESS;
            end
         endcase
      end
   end

   // request fields stay put until the next acceptance
   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         dev.req_addr  <= addr;
         dev.req_opc   <= opc;
         dev.req_read  <= read;
         dev.req_wdata <= din;
      end
   end

endmodule

// File: pi_slave_top.sv
// PI-bus slave top level, plain bus ports around the slave FSM and the register device
`timescale 1ns/1ps

module pi_slave_top (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      sel,
   input  logic [pi_pkg::ADDR_W-1:0] addr,
   input  logic [pi_pkg::OPC_W-1:0]  opc,
   input  logic                      read,
   input  logic [pi_pkg::DATA_W-1:0] din,
   input  logic                      tout,
   output pi_pkg::ack_t              ack,
   output logic [pi_pkg::DATA_W-1:0] dout
);

   pi_dev_if dev_if ();                // FSM to device link

   pi_slave_fsm pi_slave_fsm_inst (
      .clk   (clk),
      .rst_n (rst_n),
      .sel   (sel),
      .addr  (addr),
      .opc   (opc),
      .read  (read),
      .din   (din),
      .tout  (tout),
      .ack   (ack),
      .dout  (dout),
      .dev   (dev_if.fsm)
   );

   pi_reg_device pi_reg_device_inst (
      .clk   (clk),
      .rst_n (rst_n),
      .dev   (dev_if.dev)
   );

endmodule

// File: pi_slave_assert.sv
// acknowledge protocol assertions, bound into the PI-bus slave top level by the testbench
`timescale 1ns/1ps

module pi_slave_assert (
   input logic                      clk,
   input logic                      rst_n,
   input pi_pkg::ack_t              ack,
   input logic [pi_pkg::DATA_W-1:0] dout,
   input logic                      tout
);
   import pi_pkg::*;

   int fire_cnt = 0;                   // assertion failures so far

   ack_known: assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(ack))
      else
      begin
         $error("ack unknown");
         fire_cnt++;
      end

   rdy_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
      ack == ACK_RDY |=> ack != ACK_RDY)
      else
      begin
         $error("RDY held longer than one cycle");
         fire_cnt++;
      end

   err_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
      ack == ACK_ERR |=> ack != ACK_ERR)
      else
      begin
         $error("ERR held longer than one cycle");
         fire_cnt++;
      end

   // wait ends in completion, or in idle when the master gave up
   wat_exit: assert property (@(posedge clk) disable iff (!rst_n)
      ack == ACK_WAT |=> (ack == ACK_WAT || ack == ACK_RDY || (ack == ACK_IDLE && $past(tout))))
      else
      begin
         $error("illegal exit from WAT");
         fire_cnt++;
      end

   dout_quiet: assert property (@(posedge clk) disable iff (!rst_n)
      ack != ACK_RDY |-> dout == '0)
      else
      begin
         $error("dout driven without RDY");
         fire_cnt++;
      end

endmodule

// File: pi_slave_checker.sv
// testbench monitor for the PI-bus slave, judges each transfer's ack and dout and keeps counts
`timescale 1ns/1ps

module pi_slave_checker #(
   parameter int CASE_LIMIT = 40
) (
   input logic                      clk,
   input logic                      rst_n,
   input pi_pkg::ack_t              ack,
   input logic [pi_pkg::DATA_W-1:0] dout,
   input logic                      start,
   input logic                      exp_read,
   input logic [2:0]                exp_ack,
   input logic [pi_pkg::DATA_W-1:0] exp_data,
   input logic                      exp_tout,
   input logic [pi_pkg::ADDR_W-1:0] exp_addr,
   output int                       pass_cnt,
   output int                       fail_cnt
);
   import pi_pkg::*;

   logic              active;        // a transfer is being watched
   logic              c_read;
   logic [2:0]        c_ack;
   logic [DATA_W-1:0] c_data;
   logic              c_tout;
   logic [ADDR_W-1:0] c_addr;
   logic              seen_wat;
   int                cycles;
   int                wat_cnt;
   int                case_no;

   task automatic judge();
      logic [DATA_W-1:0] want;
      bit                ok;
      ok   = 1'b1;
      want = (c_read && c_ack == ACK_RDY) ? c_data : '0;   // dout only on a read RDY
      if (ack !== c_ack)
      begin
         $display("Mismatch at %0t: ack expected %b got %b", $time, c_ack, ack);
         ok = 1'b0;
      end
      if (dout !== want)
      begin
         $display("Mismatch at %0t: dout expected %h got %h", $time, want, dout);
         ok = 1'b0;
      end
      if (c_read && c_ack == ACK_RDY && wat_cnt < RD_LAT)
      begin
         $display("case %0d read finished after %0d wait cycles, the lookup alone takes %0d",
                  case_no, wat_cnt, RD_LAT);
         ok = 1'b0;
      end
      if (ok)
         pass_cnt++;
      else
         fail_cnt++;
      $display("case %0d %s addr %h: ack %b dout %h, %0d wait cycles, %s", case_no,
               c_read ? "read" : "write", c_addr, ack, dout, wat_cnt, ok ? "ok" : "bad");
      active = 1'b0;
   endtask

   task automatic print_summary(input int assert_fails);
      if (active)
      begin
         $display("case %0d never finished", case_no);
         fail_cnt++;
      end
      $display("cases passed %0d, failed %0d, assertion failures %0d",
               pass_cnt, fail_cnt, assert_fails);
   endtask

   // values sampled here were set at the previous rising edge
   always @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         active   = 1'b0;
         pass_cnt = 0;
         fail_cnt = 0;
         case_no  = 0;
      end
      else
      begin
         if (active)
         begin
            cycles++;
            if (ack == ACK_RDY || ack == ACK_ERR)
               judge();
            else if (ack == ACK_IDLE && seen_wat && c_tout)
               judge();
            else if (ack == ACK_WAT)
            begin
               seen_wat = 1'b1;
               wat_cnt++;
            end
            if (active && cycles > CASE_LIMIT)
            begin
               $display("case %0d got no response from the DUT within %0d cycles",
                        case_no, CASE_LIMIT);
               fail_cnt++;
               active = 1'b0;
            end
         end
         if (start)
         begin
            if (active)
            begin
               $display("case %0d got no response before the next transfer began", case_no);
               fail_cnt++;
            end
            case_no++;
            active   = 1'b1;                // new request latched after the old one closes
            c_read   = exp_read;
            c_ack    = exp_ack;
            c_data   = exp_data;
            c_tout   = exp_tout;
            c_addr   = exp_addr;
            seen_wat = 1'b0;
            cycles   = 0;
            wat_cnt  = 0;
         end
      end
   end

endmodule

// File: tb_pi_slave.sv
// testbench top for the PI-bus slave, runs transfers from the case file and reports the result
`timescale 1ns/1ps

module tb_pi_slave;
   import pi_pkg::*;

   localparam int      HALF_PERIOD = 50;      // 100 ns clock
   localparam int      CASE_LIMIT  = 40;      // cycles allowed per transfer
   localparam logic [31:0] SEED    = 32'd54924;

   logic              clk;
   logic              rst_n;
   logic              sel;
   logic [ADDR_W-1:0] addr;
   logic [OPC_W-1:0]  opc;
   logic              read;
   logic [DATA_W-1:0] din;
   logic              tout;
   ack_t              ack;
   logic [DATA_W-1:0] dout;

   logic              start;                  // one pulse per new transfer
   logic              exp_read;
   logic [2:0]        exp_ack;
   logic [DATA_W-1:0] exp_data;
   logic              exp_tout;
   logic [ADDR_W-1:0] exp_addr;
   int                pass_cnt;
   int                fail_cnt;

   logic [7:0]        kinds [$];              // W, R, or B for a write with no idle gap
   logic [ADDR_W-1:0] addrs [$];
   logic [OPC_W-1:0]  opcs [$];
   logic [DATA_W-1:0] datas [$];
   logic [2:0]        acks [$];
   logic              touts [$];
   logic [31:0]       rng;
   int                cyc;
   int                cyc_limit;

   pi_slave_top pi_slave_top_inst (
      .clk   (clk),
      .rst_n (rst_n),
      .sel   (sel),
      .addr  (addr),
      .opc   (opc),
      .read  (read),
      .din   (din),
      .tout  (tout),
      .ack   (ack),
      .dout  (dout)
   );

   pi_slave_checker #(.CASE_LIMIT(CASE_LIMIT)) chk_inst (
      .clk      (clk),
      .rst_n    (rst_n),
      .ack      (ack),
      .dout     (dout),
      .start    (start),
      .exp_read (exp_read),
      .exp_ack  (exp_ack),
      .exp_data (exp_data),
      .exp_tout (exp_tout),
      .exp_addr (exp_addr),
      .pass_cnt (pass_cnt),
      .fail_cnt (fail_cnt)
   );

   bind pi_slave_top pi_slave_assert pi_slave_assert_inst (
      .clk   (clk),
      .rst_n (rst_n),
      .ack   (ack),
      .dout  (dout),
      .tout  (tout)
   );

   always #(HALF_PERIOD) clk = ~clk;

   // 32-bit xorshift step
   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic load_cases();
      int                fd;
      int                n;
      string             line;
      logic [7:0]        k;
      logic [ADDR_W-1:0] a;
      logic [OPC_W-1:0]  o;
      logic [DATA_W-1:0] d;
      logic [2:0]        e;
      int                t;
      fd = $fopen("pi_cases.txt", "r");
      if (fd == 0)
      begin
         $display("cannot open the case file pi_cases.txt");
         return;
      end
      while (!$feof(fd))
      begin
         line = "";
         void'($fgets(line, fd));
         if (line.len() == 0 || line[0] == "#")
            continue;                         // header and blank lines
         n = $sscanf(line, "%c %h %h %h %h %d", k, a, o, d, e, t);
         if (n != 6)
            continue;
         kinds.push_back(k);
         addrs.push_back(a);
         opcs.push_back(o);
         datas.push_back(d);
         acks.push_back(e);
         touts.push_back(t != 0);
      end
      $fclose(fd);
   endtask

   // called on a falling edge, returns on a falling edge
   task automatic run_case(input int i);
      int gap;
      int waited;
      bit done;
      if (kinds[i] == "B")
         gap = 0;                             // back-to-back to fill the write buffer
      else
      begin
         rng = xorshift(rng);
         gap = rng % 4;
      end
      repeat (gap)
      begin
         sel  = 1'b0;
         tout = 1'b0;
         @(negedge clk);
      end
      sel      = 1'b1;
      addr     = addrs[i];
      opc      = opcs[i];
      read     = (kinds[i] == "R");
      din      = read ? '0 : datas[i];
      tout     = 1'b0;
      exp_read = read;
      exp_ack  = acks[i];
      exp_data = datas[i];
      exp_tout = touts[i];
      exp_addr = addrs[i];
      start    = 1'b1;
      waited   = 0;
      done     = 1'b0;
      while (!done && waited < CASE_LIMIT)
      begin
         @(negedge clk);
         start  = 1'b0;
         waited = waited + 1;
         if (ack == ACK_RDY || ack == ACK_ERR)
            done = 1'b1;
         else if (ack == ACK_IDLE && tout)
            done = 1'b1;                      // abandoned transfer is over
         else if (ack == ACK_WAT && touts[i])
            tout = 1'b1;                      // give up at the first wait
      end
   endtask

   always @(posedge clk)
   begin
      cyc = cyc + 1;
      if (cyc_limit > 0 && cyc >= cyc_limit)
      begin
         $display("run stopped after %0d cycles, the DUT stopped responding", cyc);
         $display("Verification failed");
         $finish;
      end
   end

   initial
   begin
      clk       = 1'b0;
      rst_n     = 1'b0;
      sel       = 1'b0;
      addr      = '0;
      opc       = '0;
      read      = 1'b0;
      din       = '0;
      tout      = 1'b0;
      start     = 1'b0;
      exp_read  = 1'b0;
      exp_ack   = '0;
      exp_data  = '0;
      exp_tout  = 1'b0;
      exp_addr  = '0;
      rng       = SEED;
      cyc       = 0;
      cyc_limit = 0;
      load_cases();
      cyc_limit = kinds.size() * CASE_LIMIT + 20 + 8;   // reset cycles on top
      repeat (8) @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      for (int i = 0; i < kinds.size(); i++)
         run_case(i);
      sel  = 1'b0;
      tout = 1'b0;
      repeat (4) @(negedge clk);
      chk_inst.print_summary(pi_slave_top_inst.pi_slave_assert_inst.fire_cnt);
      if (kinds.size() > 0 && fail_cnt == 0 && pass_cnt == kinds.size() &&
          pi_slave_top_inst.pi_slave_assert_inst.fire_cnt == 0)
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   end

endmodule

// File: pi_cases.txt
# kind(W/R/B=write no gap) addr(hex) opc(hex) data(hex, write or expected read) ack(hex) tout
# ack codes 1 RDY, 4 ERR, 0 IDLE after an abandoned read
W 0 2 11111111 1 0
W 3 2 33333333 1 0
W 7 2 77777777 1 0
W f 2 ffff0000 1 0
R 0 2 11111111 1 0
R 3 2 33333333 1 0
R 7 2 77777777 1 0
R f 2 ffff0000 1 0
R 1 2 00000000 1 0
W 5 2 aaaa0001 1 0
B 5 2 aaaa0002 1 0
B 5 2 aaaa0003 1 0
R 5 2 aaaa0003 1 0
W 8 2 80000008 1 0
B 9 2 90000009 1 0
B a 2 a000000a 1 0
B b 2 b000000b 1 0
B c 2 c000000c 1 0
B d 2 d000000d 1 0
B e 2 e000000e 1 0
B 4 2 40000004 1 0
R 8 2 80000008 1 0
R b 2 b000000b 1 0
R e 2 e000000e 1 0
R 4 2 40000004 1 0
W 10 2 deadbeef 4 0
W 3 3 deadbeef 4 0
R 3fffffff 2 00000000 4 0
R 3 0 00000000 4 0
R 3 2 33333333 1 0
R 5 2 00000000 0 1
R 7 2 77777777 1 0

// File: flist.f
pi_pkg.sv
pi_dev_if.sv
pi_fifo.sv
pi_reg_device.sv
pi_slave_fsm.sv
pi_slave_top.sv
pi_slave_assert.sv
pi_slave_checker.sv
tb_pi_slave.sv
